// File: common/hdmi_cfg.svh
// Raster timing, data island layout and fixed TMDS symbol codes, included by core and checks
`ifndef HDMI_CFG_SVH
`define HDMI_CFG_SVH

// 720x480p at 60 Hz
`define DISPLAY_WIDTH       720
`define DISPLAY_HEIGHT      480
`define FULL_WIDTH          858
`define FULL_HEIGHT         525
`define H_FRONT_PORCH       16
`define H_SYNC              62
`define V_FRONT_PORCH       9
`define V_SYNC              6

// Data island in the horizontal blanking, four control cycles after active video
`define DATA_START          724
`define DATA_PREAMBLE       8
`define DATA_GUARDBAND      2
`define DATA_SIZE           32

// Leading edge of active video
`define VIDEO_PREAMBLE      8
`define VIDEO_GUARDBAND     2

// Control period codes, indexed by the two control bits
`define CTL_CODE0           10'b1101010100
`define CTL_CODE1           10'b0010101011
`define CTL_CODE2           10'b0101010100
`define CTL_CODE3           10'b1010101011

// Guard band symbols
`define VIDEO_GUARD_SYM     10'b1011001100
`define DATA_GUARD_SYM      10'b0100110011

// Cycles from the period flags to the matching symbol on the output
`define PIPE_LATENCY        4

`endif

// File: common/hdmiPkg.sv
// Shared HDMI types and fixed AVI infoframe contents, referenced by scoped name from the core
`default_nettype none

package hdmiPkg;

	// One input pixel as sampled from the video source
	typedef struct packed {
		logic [7:0] red;
		logic [7:0] green;
		logic [7:0] blue;
	} rgbPixel;

	typedef struct packed {
		logic [9:0] x;
		logic [9:0] y;
	} screenPos;

	// Both syncs are active low, vSync in the upper bit to match the control pair
	typedef struct packed {
		logic vSync;
		logic hSync;
	} syncCtl;

	typedef struct packed {
		logic drawArea;
		logic videoPreamble;
		logic dataPreamble;
		logic dataGuard;
		logic dataIsland;
		logic videoGuard;
	} periodFlags;

	// ch0 is blue, ch1 green, ch2 red
	typedef struct packed {
		logic [3:0] ch2;
		logic [3:0] ch1;
		logic [3:0] ch0;
	} terc4Nibbles;

	typedef struct packed {
		logic [9:0] ch2;
		logic [9:0] ch1;
		logic [9:0] ch0;
	} tmdsSymbols;

	// AVI infoframe, type 0x82, version 2, length 13
	localparam logic [23:0] AVI_HEADER = 24'h0D0282;
	// Checksum 0x32, RGB with active format same as picture, 16:9 picture, VIC 3
	localparam logic [55:0] AVI_SUBPACKET0 = 56'h000003002A1032;

	// BCH generator taps on bits 0, 6 and 7
	localparam logic [7:0] BCH_POLY = 8'hC1;

endpackage

`default_nettype wire

// File: verilog/hdmiVideoTiming.sv
// Raster generator for the transmitter, giving registered syncs, period flags and position
`default_nettype none
`include "hdmi_cfg.svh"

module hdmiVideoTiming (
	input  logic                pixclk,
	input  logic                rstN,
	output hdmiPkg::syncCtl     sync,
	output hdmiPkg::periodFlags flags,
	output hdmiPkg::screenPos   pos,
	output logic                pixReq
);

	localparam logic [9:0] X_LAST = 10'(`FULL_WIDTH - 1);
	localparam logic [9:0] Y_LAST = 10'(`FULL_HEIGHT - 1);
	localparam logic [9:0] H_SYNC_START = 10'(`DISPLAY_WIDTH + `H_FRONT_PORCH);
	localparam logic [9:0] H_SYNC_END = 10'(`DISPLAY_WIDTH + `H_FRONT_PORCH + `H_SYNC);
	localparam logic [9:0] V_SYNC_LINE = 10'(`DISPLAY_HEIGHT + `V_FRONT_PORCH - 1);
	localparam logic [9:0] V_SYNC_LAST = 10'(`DISPLAY_HEIGHT + `V_FRONT_PORCH + `V_SYNC - 1);
	localparam logic [9:0] ISLAND_START = 10'(`DATA_START + `DATA_PREAMBLE);
	localparam logic [9:0] BODY_START = 10'(`DATA_START + `DATA_PREAMBLE + `DATA_GUARDBAND);
	localparam logic [9:0] TRAIL_START = 10'(BODY_START + `DATA_SIZE);
	localparam logic [9:0] ISLAND_END = 10'(TRAIL_START + `DATA_GUARDBAND);
	localparam logic [9:0] VPRE_START = 10'(`FULL_WIDTH - `VIDEO_PREAMBLE - `VIDEO_GUARDBAND);
	localparam logic [9:0] VGUARD_START = 10'(`FULL_WIDTH - `VIDEO_GUARDBAND);

	logic [9:0] x;
	logic [9:0] y;
	logic vSyncOn;
	logic vSyncOff;
	hdmiPkg::syncCtl syncNext;
	hdmiPkg::periodFlags flagsNext;

	// Free running raster position
	always_ff @(posedge pixclk) begin
		if (!rstN) begin
			x <= '0;
			y <= '0;
		end else if (x == X_LAST) begin
			x <= '0;
			y <= (y == Y_LAST) ? 10'd0 : y + 10'd1;
		end else begin
			x <= x + 10'd1;
		end
	end

	// vSync edges line up with the hSync falling edge
	assign vSyncOn = (y == V_SYNC_LINE && x >= H_SYNC_START) || y > V_SYNC_LINE;
	assign vSyncOff = (y == V_SYNC_LAST && x < H_SYNC_START) || y < V_SYNC_LAST;

	always_comb begin
		syncNext.hSync = !(x >= H_SYNC_START && x < H_SYNC_END);
		syncNext.vSync = !(vSyncOn && vSyncOff);
		flagsNext.drawArea = (x < 10'(`DISPLAY_WIDTH)) && (y < 10'(`DISPLAY_HEIGHT));
		flagsNext.dataPreamble = (x >= 10'(`DATA_START)) && (x < ISLAND_START);
		flagsNext.dataIsland = (x >= ISLAND_START) && (x < ISLAND_END);
		flagsNext.dataGuard = (x >= ISLAND_START && x < BODY_START) ||
			(x >= TRAIL_START && x < ISLAND_END);
		flagsNext.videoPreamble = (x >= VPRE_START) && (x < VGUARD_START);
		flagsNext.videoGuard = x >= VGUARD_START;
	end

	always_ff @(posedge pixclk) begin
		if (!rstN) begin
			sync <= 2'b11;
			flags <= '0;
			pos <= '0;
			pixReq <= 1'b0;
		end else begin
			sync <= syncNext;
			flags <= flagsNext;
			pos.x <= x;
			pos.y <= y;
			pixReq <= flagsNext.drawArea;
		end
	end

endmodule

`default_nettype wire

// File: tmds/tmdsEncoder.sv
// Two-stage TMDS 8b/10b encoder for one color channel, with control codes outside video
`default_nettype none
`include "hdmi_cfg.svh"

module tmdsEncoder (
	input  logic       pixclk,
	input  logic       rstN,
	input  logic [7:0] videoData,
	input  logic [1:0] ctlData,
	input  logic       videoEnable,
	output logic [9:0] symbol
);

	logic [8:0] qmNext;
	logic [8:0] qm;
	logic [1:0] ctlD;
	logic enD;
	logic useXnor;
	logic [3:0] bal;
	logic [3:0] disparity;
	logic [3:0] dispNext;
	logic [9:0] symNext;

	function automatic logic [3:0] countOnes(input logic [7:0] v);
		logic [3:0] n;
		n = '0;
		for (int i = 0; i < 8; i++)
			n = n + {3'b000, v[i]};
		return n;
	endfunction

	////////////////////////////////////////////////////////////
	// Stage 1: transition minimization
	////////////////////////////////////////////////////////////

	always_comb begin
		useXnor = countOnes(videoData) > (videoData[0] ? 4'd4 : 4'd3);
		qmNext[0] = videoData[0];
		for (int i = 1; i < 8; i++)
			qmNext[i] = useXnor ? ~(qmNext[i-1] ^ videoData[i]) : (qmNext[i-1] ^ videoData[i]);
		qmNext[8] = ~useXnor;
	end

	always_ff @(posedge pixclk) begin
		qm <= qmNext;
		ctlD <= ctlData;
	end

	always_ff @(posedge pixclk) begin
		if (!rstN)
			enD <= 1'b0;
		else
			enD <= videoEnable;
	end

	////////////////////////////////////////////////////////////
	// Stage 2: DC balancing
	////////////////////////////////////////////////////////////

	// Half the ones-minus-zeros count of the word, so disparity moves in steps of two bits
	assign bal = countOnes(qm[7:0]) - 4'd4;

	always_comb begin
		if (!enD) begin
			dispNext = '0;
			unique case (ctlD)
				2'b00: symNext = `CTL_CODE0;
				2'b01: symNext = `CTL_CODE1;
				2'b10: symNext = `CTL_CODE2;
				default: symNext = `CTL_CODE3;
			endcase
		end else if (bal == 4'd0 || disparity == 4'd0) begin
			if (qm[8]) begin
				symNext = {1'b0, qm[8], qm[7:0]};
				dispNext = disparity + bal;
			end else begin
				symNext = {1'b1, qm[8], ~qm[7:0]};
				dispNext = disparity - bal;
			end
		end else if (bal[3] == disparity[3]) begin
			// Same sign as the running total, so invert to pull back
			symNext = {1'b1, qm[8], ~qm[7:0]};
			dispNext = disparity + {3'b000, qm[8]} - bal;
		end else begin
			symNext = {1'b0, qm[8], qm[7:0]};
			dispNext = disparity - {3'b000, ~qm[8]} + bal;
		end
	end

	always_ff @(posedge pixclk) begin
		if (!rstN)
			disparity <= '0;
		else
			disparity <= dispNext;
	end

	always_ff @(posedge pixclk) begin
		symbol <= symNext;
	end

endmodule

`default_nettype wire

// File: dataIsland/islandPacketizer.sv
// Data island packet source, shifting out the AVI infoframe with BCH parity as TERC4 nibbles
`default_nettype none
`include "hdmi_cfg.svh"

module islandPacketizer (
	input  logic                 pixclk,
	input  logic                 rstN,
	input  hdmiPkg::syncCtl      sync,
	input  hdmiPkg::periodFlags  flags,
	output hdmiPkg::terc4Nibbles nibbles
);

	localparam logic [5:0] LAST_DATA = 6'(`DATA_SIZE);
	localparam logic [4:0] HDR_DATA_CYCLES = 5'(`DATA_SIZE - 8);
	localparam logic [4:0] SUB_DATA_CYCLES = 5'(`DATA_SIZE - 4);

	logic [5:0] phase;
	logic [4:0] offset;
	logic loadPkt;
	logic dataCycle;
	logic hdrPass;
	logic subPass;
	logic [23:0] header;
	logic [55:0] subPkt [4];
	logic [7:0] bchHdr;
	logic [7:0] bchSub [4];
	logic [7:0] bchHdrNext;
	logic [7:0] bchSubNext [4];
	hdmiPkg::terc4Nibbles nibNext;

	// One shift of the BCH register, feedback only while data passes through
	function automatic logic [7:0] bchStep(input logic [7:0] code, input logic dataBit,
		input logic pass);
		logic fb;
		fb = (code[7] ^ dataBit) & pass;
		return {code[6:0], 1'b0} ^ (fb ? hdmiPkg::BCH_POLY : 8'h00);
	endfunction

	////////////////////////////////////////////////////////////
	// Island phase
	////////////////////////////////////////////////////////////

	// The flags arrive one pixel ahead of the nibble being built, so phase N
	// with the island flag set means nibble N+1 of the island (guards included)
	always_ff @(posedge pixclk) begin
		if (!rstN)
			phase <= '0;
		else if (flags.dataIsland)
			phase <= phase + 6'd1;
		else
			phase <= '0;
	end

	assign offset = 5'(phase - 6'd1);
	assign loadPkt = flags.dataGuard && (phase == 6'd0);
	assign dataCycle = flags.dataIsland && (phase != 6'd0) && (phase <= LAST_DATA);
	assign hdrPass = offset < HDR_DATA_CYCLES;
	assign subPass = offset < SUB_DATA_CYCLES;

	////////////////////////////////////////////////////////////
	// Nibble forming
	////////////////////////////////////////////////////////////

	always_comb begin
		bchHdrNext = bchStep(bchHdr, header[0], hdrPass);
		for (int i = 0; i < 4; i++)
			bchSubNext[i] = bchStep(bchStep(bchSub[i], subPkt[i][0], subPass),
				subPkt[i][1], subPass);

		// Guard band pattern, also harmless outside the island
		nibNext.ch0 = {1'b1, 1'b1, sync.vSync, sync.hSync};
		nibNext.ch1 = '0;
		nibNext.ch2 = '0;
		if (dataCycle) begin
			// Bit 3 low marks the first cycle of the packet
			nibNext.ch0[3] = offset != 5'd0;
			nibNext.ch0[2] = hdrPass ? header[0] : bchHdr[7];
			for (int i = 0; i < 4; i++) begin
				nibNext.ch1[i] = subPass ? subPkt[i][0] : bchSub[i][7];
				nibNext.ch2[i] = subPass ? subPkt[i][1] : bchSub[i][6];
			end
		end
	end

	always_ff @(posedge pixclk) begin
		if (loadPkt) begin
			header <= hdmiPkg::AVI_HEADER;
			subPkt[0] <= hdmiPkg::AVI_SUBPACKET0;
			for (int i = 1; i < 4; i++)
				subPkt[i] <= '0;
			bchHdr <= '0;
			for (int i = 0; i < 4; i++)
				bchSub[i] <= '0;
		end else if (dataCycle) begin
			header <= header >> 1;
			bchHdr <= bchHdrNext;
			for (int i = 0; i < 4; i++) begin
				subPkt[i] <= subPkt[i] >> 2;
				bchSub[i] <= bchSubNext[i];
			end
		end
		nibbles <= nibNext;
	end

endmodule

`default_nettype wire

// File: dataIsland/terc4Encoder.sv
// Two-stage TERC4 encoder for all three channel nibbles of a data island
`default_nettype none

module terc4Encoder (
	input  logic                 pixclk,
	input  logic                 rstN,
	input  hdmiPkg::terc4Nibbles nibbles,
	output hdmiPkg::tmdsSymbols  symbols
);

	hdmiPkg::tmdsSymbols stage;

	function automatic logic [9:0] terc4Code(input logic [3:0] n);
		logic [9:0] code;
		unique case (n)
			4'h0: code = 10'b1010011100;
			4'h1: code = 10'b1001100011;
			4'h2: code = 10'b1011100100;
			4'h3: code = 10'b1011100010;
			4'h4: code = 10'b0101110001;
			4'h5: code = 10'b0100011110;
			4'h6: code = 10'b0110001110;
			4'h7: code = 10'b0100111100;
			4'h8: code = 10'b1011001100;
			4'h9: code = 10'b0100111001;
			4'hA: code = 10'b0110011100;
			4'hB: code = 10'b1011000110;
			4'hC: code = 10'b1010001110;
			4'hD: code = 10'b1001110001;
			4'hE: code = 10'b0101100011;
			default: code = 10'b1011000011;
		endcase
		return code;
	endfunction

	// Second register keeps the path as deep as the TMDS encoders
	always_ff @(posedge pixclk) begin
		if (!rstN) begin
			stage <= '0;
			symbols <= '0;
		end else begin
			stage.ch2 <= terc4Code(nibbles.ch2);
			stage.ch1 <= terc4Code(nibbles.ch1);
			stage.ch0 <= terc4Code(nibbles.ch0);
			symbols <= stage;
		end
	end

endmodule

`default_nettype wire

// File: verilog/symbolSelect.sv
// Output stage that picks the video, TERC4 or guard-band symbol for each TMDS channel
`default_nettype none
`include "hdmi_cfg.svh"

module symbolSelect (
	input  logic                pixclk,
	input  logic                rstN,
	input  hdmiPkg::periodFlags flags,
	input  hdmiPkg::tmdsSymbols tmdsSym,
	input  hdmiPkg::tmdsSymbols terc4Sym,
	output hdmiPkg::tmdsSymbols tmdsOut
);

	hdmiPkg::periodFlags flagsD1;
	hdmiPkg::periodFlags flagsD2;
	hdmiPkg::tmdsSymbols selNext;

	// Two stages, the depth of both encoder pipelines
	always_ff @(posedge pixclk) begin
		if (!rstN) begin
			flagsD1 <= '0;
			flagsD2 <= '0;
		end else begin
			flagsD1 <= flags;
			flagsD2 <= flagsD1;
		end
	end

	always_comb begin
		selNext = tmdsSym;
		if (flagsD2.videoGuard) begin
			selNext.ch2 = `VIDEO_GUARD_SYM;
			selNext.ch1 = `DATA_GUARD_SYM;
			selNext.ch0 = `VIDEO_GUARD_SYM;
		end else if (flagsD2.dataGuard) begin
			// Blue keeps carrying the syncs as TERC4 during the guard band
			selNext.ch2 = `DATA_GUARD_SYM;
			selNext.ch1 = `DATA_GUARD_SYM;
			selNext.ch0 = terc4Sym.ch0;
		end else if (flagsD2.dataIsland) begin
			selNext = terc4Sym;
		end
	end

	always_ff @(posedge pixclk) begin
		if (!rstN) begin
			// Idle control period with both syncs inactive
			tmdsOut.ch2 <= `CTL_CODE0;
			tmdsOut.ch1 <= `CTL_CODE0;
			tmdsOut.ch0 <= `CTL_CODE3;
		end else begin
			tmdsOut <= selNext;
		end
	end

endmodule

`default_nettype wire

// File: verilog/hdmiTransmitter.sv
// HDMI transmitter core top, producing three parallel TMDS symbols per pixel clock
`default_nettype none

module hdmiTransmitter (
	input  logic                pixclk,
	input  logic                rstN,
	input  hdmiPkg::rgbPixel    pixel,
	output hdmiPkg::tmdsSymbols tmdsOut,
	output hdmiPkg::screenPos   pos,
	output logic                pixReq
);

	hdmiPkg::syncCtl sync;
	hdmiPkg::periodFlags flags;
	hdmiPkg::terc4Nibbles nibbles;
	hdmiPkg::tmdsSymbols tmdsSym;
	hdmiPkg::tmdsSymbols terc4Sym;
	logic [1:0] ctlRed;
	logic [1:0] ctlGreen;

	// Preamble control bits, 0101 before a data island and 0001 before video
	assign ctlRed = {1'b0, flags.dataPreamble};
	assign ctlGreen = {1'b0, flags.dataPreamble | flags.videoPreamble};

	hdmiVideoTiming u_timing (
		.pixclk (pixclk),
		.rstN   (rstN),
		.sync   (sync),
		.flags  (flags),
		.pos    (pos),
		.pixReq (pixReq)
	);

	tmdsEncoder u_encRed (
		.pixclk      (pixclk),
		.rstN        (rstN),
		.videoData   (pixel.red),
		.ctlData     (ctlRed),
		.videoEnable (flags.drawArea),
		.symbol      (tmdsSym.ch2)
	);

	tmdsEncoder u_encGreen (
		.pixclk      (pixclk),
		.rstN        (rstN),
		.videoData   (pixel.green),
		.ctlData     (ctlGreen),
		.videoEnable (flags.drawArea),
		.symbol      (tmdsSym.ch1)
	);

	tmdsEncoder u_encBlue (
		.pixclk      (pixclk),
		.rstN        (rstN),
		.videoData   (pixel.blue),
		.ctlData     ({sync.vSync, sync.hSync}),
		.videoEnable (flags.drawArea),
		.symbol      (tmdsSym.ch0)
	);

	islandPacketizer u_packetizer (
		.pixclk  (pixclk),
		.rstN    (rstN),
		.sync    (sync),
		.flags   (flags),
		.nibbles (nibbles)
	);

	terc4Encoder u_terc4 (
		.pixclk  (pixclk),
		.rstN    (rstN),
		.nibbles (nibbles),
		.symbols (terc4Sym)
	);

	symbolSelect u_select (
		.pixclk   (pixclk),
		.rstN     (rstN),
		.flags    (flags),
		.tmdsSym  (tmdsSym),
		.terc4Sym (terc4Sym),
		.tmdsOut  (tmdsOut)
	);

endmodule

`default_nettype wire

// File: sim/hdmiClockGen.sv
// Testbench clock and synchronous reset source for the HDMI transmitter simulation
`default_nettype none

module hdmiClockGen #(
	parameter int PERIOD = 8,
	parameter int RESET_CYCLES = 4
) (
	output logic pixclk,
	output logic rstN
);

	initial begin
		pixclk = 1'b0;
		rstN = 1'b0;
		repeat (RESET_CYCLES) @(posedge pixclk);
		rstN <= 1'b1;
	end

	always #(PERIOD / 2) pixclk = ~pixclk;

endmodule

`default_nettype wire

// File: sim/hdmi_sva.sv
// Concurrent checks on the transmitter period flags and draw area, bound into the top level
`default_nettype none
`include "hdmi_cfg.svh"

module hdmi_sva (
	input wire logic                pixclk,
	input wire logic                rstN,
	input wire hdmiPkg::periodFlags flags,
	input wire hdmiPkg::screenPos   pos,
	input wire logic                pixReq
);

	// A guard band leads into the island body or closes the island
	guardThenIsland: assert property (@(posedge pixclk) disable iff (!rstN)
		flags.dataGuard |=> (flags.dataIsland || flags == '0))
		else $error("data guard band not followed by island or idle");

	guardOutsideVideo: assert property (@(posedge pixclk) disable iff (!rstN)
		!(flags.videoGuard && flags.drawArea))
		else $error("video guard band overlaps the draw area");

	reqInActiveLines: assert property (@(posedge pixclk) disable iff (!rstN)
		pixReq |-> (pos.y < 10'(`DISPLAY_HEIGHT)))
		else $error("pixel request outside the active lines");

endmodule

`default_nettype wire

// File: sim/hdmiTb.sv
// Random-pixel testbench for the HDMI transmitter, checking every output slot against a model
`default_nettype none
`include "hdmi_cfg.svh"

module hdmiTb;

	localparam int FRAME = `FULL_WIDTH * `FULL_HEIGHT;
	localparam int RUN_CYCLES = 2 * FRAME + 16;
	localparam int TIMEOUT = 3 * FRAME * 8;

	logic pixclk;
	logic rstN;
	hdmiPkg::rgbPixel pixel;
	hdmiPkg::tmdsSymbols tmdsOut;
	hdmiPkg::screenPos pos;
	logic pixReq;

	logic [31:0] rng = 32'd49;
	logic [23:0] pixHist [16];
	int highEdges = 0;
	int released = 0;
	int mismatches = 0;
	int otherErrors = 0;
	int disp [3];
	logic [7:0] hdrParity;
	logic [7:0] subParity;

	hdmiClockGen #(.PERIOD(8), .RESET_CYCLES(4)) u_clk (.pixclk(pixclk), .rstN(rstN));

	hdmiTransmitter u_dut (
		.pixclk  (pixclk),
		.rstN    (rstN),
		.pixel   (pixel),
		.tmdsOut (tmdsOut),
		.pos     (pos),
		.pixReq  (pixReq)
	);

	bind hdmiTransmitter hdmi_sva u_sva (
		.pixclk (pixclk),
		.rstN   (rstN),
		.flags  (flags),
		.pos    (pos),
		.pixReq (pixReq)
	);

	////////////////////////////////////////////////////////////
	// Model functions
	////////////////////////////////////////////////////////////

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] v;
		v = s ^ (s << 13);
		v = v ^ (v >> 17);
		v = v ^ (v << 5);
		return v;
	endfunction

	function automatic logic hSyncAt(input int x);
		return !(x >= 736 && x < 798);
	endfunction

	// Low from line 488 at x 736 up to line 494 at x 736
	function automatic logic vSyncAt(input int x, input int y);
		return !((y == 488 && x >= 736) || (y > 488 && y < 494) || (y == 494 && x < 736));
	endfunction

	function automatic logic [9:0] ctlCode(input logic [1:0] c);
		case (c)
			2'b00: return `CTL_CODE0;
			2'b01: return `CTL_CODE1;
			2'b10: return `CTL_CODE2;
			default: return `CTL_CODE3;
		endcase
	endfunction

	// Bit 4 set flags a symbol outside the TERC4 set
	function automatic logic [4:0] terc4Decode(input logic [9:0] s);
		case (s)
			10'b1010011100: return 5'h0;
			10'b1001100011: return 5'h1;
			10'b1011100100: return 5'h2;
			10'b1011100010: return 5'h3;
			10'b0101110001: return 5'h4;
			10'b0100011110: return 5'h5;
			10'b0110001110: return 5'h6;
			10'b0100111100: return 5'h7;
			10'b1011001100: return 5'h8;
			10'b0100111001: return 5'h9;
			10'b0110011100: return 5'hA;
			10'b1011000110: return 5'hB;
			10'b1010001110: return 5'hC;
			10'b1001110001: return 5'hD;
			10'b0101100011: return 5'hE;
			10'b1011000011: return 5'hF;
			default: return 5'h10;
		endcase
	endfunction

	function automatic logic [7:0] tmdsDecode(input logic [9:0] s);
		logic [7:0] d;
		logic [7:0] q;
		d = s[9] ? ~s[7:0] : s[7:0];
		q[0] = d[0];
		for (int i = 1; i < 8; i++)
			q[i] = s[8] ? (d[i] ^ d[i-1]) : ~(d[i] ^ d[i-1]);
		return q;
	endfunction

	function automatic int balanceOf(input logic [9:0] s);
		int n;
		n = 0;
		for (int i = 0; i < 10; i++)
			n = n + (s[i] ? 1 : -1);
		return n;
	endfunction

	function automatic logic [7:0] bchCalc(input logic [55:0] bits, input int count);
		logic [7:0] code;
		logic fb;
		code = '0;
		for (int i = 0; i < count; i++) begin
			fb = code[7] ^ bits[i];
			code = {code[6:0], 1'b0} ^ (fb ? hdmiPkg::BCH_POLY : 8'h00);
		end
		return code;
	endfunction

	////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////

	task automatic reportMismatch(input string what, input logic [9:0] got,
		input logic [9:0] exp);
		mismatches++;
		$display("Mismatch at time %0t: %s got %b expected %b", $time, what, got, exp);
	endtask

	task automatic checkSym(input string what, input logic [9:0] got, input logic [9:0] exp);
		if (got !== exp)
			reportMismatch(what, got, exp);
	endtask

	task automatic checkTerc4(input string what, input logic [9:0] sym, input logic [3:0] exp);
		logic [4:0] dec;
		dec = terc4Decode(sym);
		if (dec[4]) begin
			otherErrors++;
			$display("Invalid TERC4 symbol %b on %s at time %0t", sym, what, $time);
		end else if (dec[3:0] !== exp) begin
			reportMismatch(what, {6'b0, dec[3:0]}, {6'b0, exp});
		end
	endtask

	// Island nibbles are built from the syncs one position earlier
	task automatic checkIsland(input int k, input int x, input int y);
		logic [3:0] ch0;
		logic [3:0] ch1;
		logic [3:0] ch2;
		int m;
		ch0[1:0] = {vSyncAt(x - 1, y), hSyncAt(x - 1)};
		ch0[3] = k != 0;
		ch0[2] = (k < 24) ? hdmiPkg::AVI_HEADER[k] : hdrParity[7 - (k - 24)];
		ch1 = '0;
		ch2 = '0;
		if (k < 28) begin
			ch1[0] = hdmiPkg::AVI_SUBPACKET0[2 * k];
			ch2[0] = hdmiPkg::AVI_SUBPACKET0[2 * k + 1];
		end else begin
			m = k - 28;
			ch1[0] = subParity[7 - 2 * m];
			ch2[0] = subParity[6 - 2 * m];
		end
		checkTerc4("island ch0", tmdsOut.ch0, ch0);
		checkTerc4("island ch1", tmdsOut.ch1, ch1);
		checkTerc4("island ch2", tmdsOut.ch2, ch2);
	endtask

	task automatic checkVideo(input int idx, input int x);
		hdmiPkg::rgbPixel exp;
		exp = pixHist[idx & 15];
		checkSym("video red", {2'b0, tmdsDecode(tmdsOut.ch2)}, {2'b0, exp.red});
		checkSym("video green", {2'b0, tmdsDecode(tmdsOut.ch1)}, {2'b0, exp.green});
		checkSym("video blue", {2'b0, tmdsDecode(tmdsOut.ch0)}, {2'b0, exp.blue});
		if (x == 0)
			disp = '{0, 0, 0};
		disp[0] += balanceOf(tmdsOut.ch0);
		disp[1] += balanceOf(tmdsOut.ch1);
		disp[2] += balanceOf(tmdsOut.ch2);
		// Bit balance of 16 equals 8 in the encoder's half units
		for (int i = 0; i < 3; i++) begin
			if (disp[i] > 16 || disp[i] < -16) begin
				otherErrors++;
				$display("Running disparity %0d out of range on channel %0d at time %0t",
					disp[i], i, $time);
			end
		end
	endtask

	task automatic checkSlot(input int idx);
		int x;
		int y;
		logic pre;
		logic vpre;
		x = idx % `FULL_WIDTH;
		y = (idx / `FULL_WIDTH) % `FULL_HEIGHT;
		pre = x >= 724 && x < 732;
		vpre = x >= 848 && x < 856;
		if (x >= 856) begin
			checkSym("video guard ch2", tmdsOut.ch2, `VIDEO_GUARD_SYM);
			checkSym("video guard ch1", tmdsOut.ch1, `DATA_GUARD_SYM);
			checkSym("video guard ch0", tmdsOut.ch0, `VIDEO_GUARD_SYM);
		end else if ((x >= 732 && x < 734) || (x >= 766 && x < 768)) begin
			checkSym("data guard ch2", tmdsOut.ch2, `DATA_GUARD_SYM);
			checkSym("data guard ch1", tmdsOut.ch1, `DATA_GUARD_SYM);
			checkTerc4("data guard ch0", tmdsOut.ch0,
				{2'b11, vSyncAt(x - 1, y), hSyncAt(x - 1)});
		end else if (x >= 734 && x < 766) begin
			checkIsland(x - 734, x, y);
		end else if (x < `DISPLAY_WIDTH && y < `DISPLAY_HEIGHT) begin
			checkVideo(idx, x);
		end else begin
			checkSym("control ch2", tmdsOut.ch2, ctlCode({1'b0, pre}));
			checkSym("control ch1", tmdsOut.ch1, ctlCode({1'b0, pre | vpre}));
			checkSym("control ch0", tmdsOut.ch0, ctlCode({vSyncAt(x, y), hSyncAt(x)}));
		end
	endtask

	task automatic checkIdle();
		checkSym("reset ch2", tmdsOut.ch2, `CTL_CODE0);
		checkSym("reset ch1", tmdsOut.ch1, `CTL_CODE0);
		checkSym("reset ch0", tmdsOut.ch0, `CTL_CODE3);
	endtask

	////////////////////////////////////////////////////////////
	// Stimulus, sampling and verdict
	////////////////////////////////////////////////////////////

	// Pixel driven on high edge h belongs to raster position h-1
	always @(posedge pixclk) begin
		rng = xorshift(rng);
		pixel <= rng[23:0];
		if (rstN) begin
			highEdges++;
			pixHist[(highEdges - 1) & 15] = rng[23:0];
		end
	end

	// Outputs are stable at the falling edge
	always @(negedge pixclk) begin
		int idx;
		if (!rstN) begin
			released = 0;
			if (pixReq !== 1'b0)
				reportMismatch("pixReq in reset", {9'b0, pixReq}, 10'd0);
			checkIdle();
		end else begin
			released++;
			// pos and pixReq trail the raster counter by one register
			if (released == 1) begin
				if (pixReq !== 1'b0)
					reportMismatch("pixReq after reset", {9'b0, pixReq}, 10'd0);
			end else begin
				idx = released - 2;
				checkSym("pos.x", pos.x, 10'(idx % `FULL_WIDTH));
				checkSym("pos.y", pos.y, 10'((idx / `FULL_WIDTH) % `FULL_HEIGHT));
				checkSym("pixReq", {9'b0, pixReq}, {9'b0, (idx % `FULL_WIDTH) < `DISPLAY_WIDTH
					&& ((idx / `FULL_WIDTH) % `FULL_HEIGHT) < `DISPLAY_HEIGHT});
			end
			if (released <= `PIPE_LATENCY)
				checkIdle();
			else
				checkSlot(released - 1 - `PIPE_LATENCY);
		end
	end

	initial begin
		#(TIMEOUT);
		$display("Watchdog timeout, the run did not finish in time");
		$display("Some tests failed");
		$finish;
	end

	initial begin
		pixel = '0;
		disp = '{0, 0, 0};
		hdrParity = bchCalc({32'b0, hdmiPkg::AVI_HEADER}, 24);
		subParity = bchCalc(hdmiPkg::AVI_SUBPACKET0, 56);
		wait (rstN === 1'b1);
		repeat (RUN_CYCLES) @(posedge pixclk);
		$display("Errors: %0d mismatches, %0d other failures", mismatches, otherErrors);
		if (mismatches == 0 && otherErrors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: build.f
+incdir+common
common/hdmiPkg.sv
verilog/hdmiVideoTiming.sv
tmds/tmdsEncoder.sv
dataIsland/islandPacketizer.sv
dataIsland/terc4Encoder.sv
verilog/symbolSelect.sv
verilog/hdmiTransmitter.sv
sim/hdmiClockGen.sv
sim/hdmi_sva.sv
sim/hdmiTb.sv

// File: Makefile
TOP = hdmiTb
LOG = sim.log

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal -f build.f --top-module $(TOP) -o simv

run: compile
	./obj_dir/simv > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Some tests failed" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@if ! grep -q "All tests passed" $(LOG); then echo "Simulation incomplete"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
